/* rtl/chart_play_settings.svh */
`ifndef CHART_PLAY_SETTINGS_SVH
`define CHART_PLAY_SETTINGS_SVH
`default_nettype none

// Chart geometry
`define CHART_LEN 64
`define CHART_AW 6

// Tick periods in prog_clk cycles
`define COUNT_TICKS 48
`define SCAN_TICKS 24
`define NOTE_SCANS 4

// Points per scan
`define HIT_NOW_PTS 5
`define HIT_LATE1_PTS 3
`define HIT_LATE2_PTS 2
`define AUTO_PTS 4
`define MAX_PTS 5

// APB map, registers sit just above the chart words
`define APB_AW 8
`define APB_DW 32
`define ADDR_NOTE_CNT 8'h40
`define ADDR_CTRL 8'h41
`define ADDR_SCORE 8'h42
`define ADDR_STATUS 8'h43

`default_nettype wire
`endif

/* rtl/chart_play_pkg.sv */
`include "chart_play_settings.svh"
`default_nettype none

package chart_play_pkg;

    typedef logic [`CHART_AW-1:0] chart_addr_t;
    // One extra bit so a full chart can be counted
    typedef logic [`CHART_AW:0] note_cnt_t;
    typedef logic [`APB_AW-1:0] apb_addr_t;
    typedef logic [`APB_DW-1:0] apb_data_t;

    typedef struct packed {
        logic       oct_down;
        logic       oct_up;
        logic [6:0] keys;     // One-hot, C on bit 0
    } note_t;

    typedef logic [13:0] score_t;

    typedef enum logic [1:0] {
        IDLE,
        COUNTDOWN,
        PLAYING,
        DONE
    } play_state_e;

    // APB address decode result
    typedef enum logic [2:0] {
        SEL_CHART,
        SEL_NOTE_CNT,
        SEL_CTRL,
        SEL_SCORE,
        SEL_STATUS,
        SEL_NONE
    } reg_sel_e;

    typedef struct packed {
        logic        valid;
        logic        write;
        chart_addr_t addr;
        note_t       wdata;
    } mem_req_t;

    typedef struct packed {
        logic      start;
        logic      auto_play;
        note_cnt_t note_cnt;
    } play_ctrl_t;

endpackage

`default_nettype wire

/* rtl/chart_ram_arbiter.sv */
`include "chart_play_settings.svh"
`default_nettype none

module chart_ram_arbiter import chart_play_pkg::*; (
    input  logic     prog_clk,
    input  logic     rst,
    input  mem_req_t apb_req,
    input  mem_req_t seq_req,
    input  mem_req_t judge_req,
    output logic     apb_gnt,
    output logic     seq_gnt,
    output logic     judge_gnt,
    output note_t    rdata
);

    note_t    chart_mem [`CHART_LEN];
    mem_req_t sel_req;

    // Fixed priority: host port, then sequencer, then judge
    always_comb begin
        apb_gnt   = apb_req.valid;
        seq_gnt   = seq_req.valid && !apb_req.valid;
        judge_gnt = judge_req.valid && !apb_req.valid && !seq_req.valid;
        if (apb_gnt) begin
            sel_req = apb_req;
        end else if (seq_gnt) begin
            sel_req = seq_req;
        end else begin
            sel_req = judge_req;
        end
    end

    always_ff @(posedge prog_clk) begin
        if (sel_req.valid && sel_req.write) begin
            chart_mem[sel_req.addr] <= sel_req.wdata;
        end
    end

    // Read data shows up the cycle after the grant
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else if (sel_req.valid && !sel_req.write) begin
            rdata <= chart_mem[sel_req.addr];
        end
    end

endmodule

`default_nettype wire

/* rtl/apb_chart_port.sv */
`include "chart_play_settings.svh"
`default_nettype none

module chart_apb_port import chart_play_pkg::*; (
    input  logic        prog_clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_addr_t   paddr,
    input  apb_data_t   pwdata,
    output apb_data_t   prdata,
    output logic        pready,
    output logic        pslverr,
    output mem_req_t    mem_req,
    input  logic        mem_gnt,
    input  note_t       mem_rdata,
    output play_ctrl_t  ctrl,
    input  play_state_e state,
    input  score_t      score,
    input  score_t      max_score
);

    reg_sel_e  sel;
    logic      access;
    logic      wr_done;
    note_cnt_t cnt_wr;

    always_comb begin
        case (paddr)
            `ADDR_NOTE_CNT: sel = SEL_NOTE_CNT;
            `ADDR_CTRL:     sel = SEL_CTRL;
            `ADDR_SCORE:    sel = SEL_SCORE;
            `ADDR_STATUS:   sel = SEL_STATUS;
            default:        sel = (paddr < `CHART_LEN) ? SEL_CHART : SEL_NONE;
        endcase
    end

    assign access  = psel && penable;
    assign wr_done = access && pready && pwrite;

    // Chart accesses wait here until the arbiter grants them
    assign mem_req = '{valid: access && (sel == SEL_CHART) && !pready,
                       write: pwrite,
                       addr:  paddr[`CHART_AW-1:0],
                       wdata: note_t'(pwdata[$bits(note_t)-1:0])};

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else if (pready) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else if (access) begin
            pready  <= (sel != SEL_CHART) || mem_gnt;
            pslverr <= (sel == SEL_NONE);
        end
    end

    // Note count saturates at the chart size
    assign cnt_wr = (pwdata > `CHART_LEN) ? note_cnt_t'(`CHART_LEN) : pwdata[`CHART_AW:0];

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            ctrl <= '0;
        end else begin
            ctrl.start <= 1'b0;
            if (wr_done && sel == SEL_NOTE_CNT) begin
                ctrl.note_cnt <= cnt_wr;
            end
            // Start only from a stopped engine
            if (wr_done && sel == SEL_CTRL && pwdata[0] && (state == IDLE || state == DONE)) begin
                ctrl.start     <= 1'b1;
                ctrl.auto_play <= pwdata[1];
            end
        end
    end

    always_comb begin
        case (sel)
            SEL_CHART:    prdata = apb_data_t'(mem_rdata);
            SEL_NOTE_CNT: prdata = apb_data_t'(ctrl.note_cnt);
            SEL_CTRL:     prdata = apb_data_t'({ctrl.auto_play, 1'b0});
            SEL_SCORE:    prdata = {16'(max_score), 16'(score)};
            SEL_STATUS:   prdata = apb_data_t'(state);
            default:      prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/note_sequencer.sv */
`include "chart_play_settings.svh"
`default_nettype none

module note_sequencer import chart_play_pkg::*; (
    input  logic        prog_clk,
    input  logic        rst,
    input  play_ctrl_t  ctrl,
    input  note_t       keys,
    output mem_req_t    mem_req,
    input  logic        mem_gnt,
    input  note_t       mem_rdata,
    output play_state_e state,
    output logic [1:0]  count_digit,
    output chart_addr_t note_idx,
    output logic        note_step,
    output logic        scan_tick,
    output note_t       played_note,
    output logic        note_valid,
    output logic [7:0]  led
);

    localparam int TICK_MAX = (`COUNT_TICKS > `SCAN_TICKS) ? `COUNT_TICKS : `SCAN_TICKS;
    localparam int TW = $clog2(TICK_MAX);
    localparam int SW = $clog2(`NOTE_SCANS);

    logic [TW-1:0] tick_cnt;
    logic [SW-1:0] scan_idx;
    logic          note_end;
    logic          fetch_pend;
    logic          rd_wait;

    // Octave LED lights for either shift
    function automatic logic [7:0] note_led(input note_t n);
        logic [7:0] l;
        l    = '0;
        l[0] = n.oct_down | n.oct_up;
        for (int i = 0; i < 7; i++) begin
            l[7 - i] = n.keys[i];
        end
        return l;
    endfunction

    assign scan_tick = (state == PLAYING) && (tick_cnt == TW'(`SCAN_TICKS - 1));
    assign note_end  = scan_tick && (scan_idx == SW'(`NOTE_SCANS - 1));
    assign note_step = (state == PLAYING) && (tick_cnt == '0) && (scan_idx == '0);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            count_digit <= 2'd0;
            tick_cnt    <= '0;
            scan_idx    <= '0;
            note_idx    <= '0;
        end else if (ctrl.start) begin
            state       <= COUNTDOWN;
            count_digit <= 2'd3;
            tick_cnt    <= '0;
            scan_idx    <= '0;
            note_idx    <= '0;
        end else begin
            case (state)
                COUNTDOWN: begin
                    if (tick_cnt == TW'(`COUNT_TICKS - 1)) begin
                        tick_cnt    <= '0;
                        count_digit <= count_digit - 2'd1;
                        if (count_digit == 2'd1) begin
                            state <= (ctrl.note_cnt == '0) ? DONE : PLAYING;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                PLAYING: begin
                    if (scan_tick) begin
                        tick_cnt <= '0;
                        scan_idx <= note_end ? '0 : scan_idx + 1'b1;
                        if (note_end) begin
                            note_idx <= note_idx + 1'b1;
                            if (note_cnt_t'(note_idx) + 1'b1 == ctrl.note_cnt) begin
                                state <= DONE;
                            end
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: tick_cnt <= '0;
            endcase
        end
    end

    assign mem_req = '{valid: fetch_pend, write: 1'b0, addr: note_idx, wdata: '0};

    // Fetch at the step, present the note once the read returns
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            fetch_pend  <= 1'b0;
            rd_wait     <= 1'b0;
            note_valid  <= 1'b0;
            played_note <= '0;
            led         <= '0;
        end else begin
            note_valid <= 1'b0;
            rd_wait    <= mem_gnt;
            if (note_step) begin
                fetch_pend <= 1'b1;
            end else if (mem_gnt) begin
                fetch_pend <= 1'b0;
            end
            if (rd_wait) begin
                note_valid  <= 1'b1;
                played_note <= ctrl.auto_play ? mem_rdata : keys;
                led         <= note_led(mem_rdata);
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/score_judge.sv */
`include "chart_play_settings.svh"
`default_nettype none

module score_judge import chart_play_pkg::*; (
    input  logic        prog_clk,
    input  logic        rst,
    input  play_ctrl_t  ctrl,
    input  play_state_e state,
    input  logic        scan_tick,
    input  chart_addr_t note_idx,
    input  note_t       keys,
    output mem_req_t    mem_req,
    input  logic        mem_gnt,
    input  note_t       mem_rdata,
    output score_t      score,
    output score_t      max_score
);

    logic        pend;
    logic        rd_wait;
    chart_addr_t addr_q;
    note_t       key_q;
    // Two previous pressed samples, newest first
    note_t       hist0;
    note_t       hist1;

    assign mem_req = '{valid: pend, write: 1'b0, addr: addr_q, wdata: '0};

    // Scan snapshot of chart index and keys
    always_ff @(posedge prog_clk) begin
        if (scan_tick) begin
            addr_q <= note_idx;
            key_q  <= keys;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            pend      <= 1'b0;
            rd_wait   <= 1'b0;
            hist0     <= '0;
            hist1     <= '0;
            score     <= '0;
            max_score <= '0;
        end else if (ctrl.start) begin
            pend      <= 1'b0;
            rd_wait   <= 1'b0;
            hist0     <= '0;
            hist1     <= '0;
            score     <= '0;
            max_score <= '0;
        end else begin
            rd_wait <= mem_gnt;
            if (state == PLAYING && scan_tick) begin
                pend <= 1'b1;
            end else if (mem_gnt) begin
                pend <= 1'b0;
            end
            // Empty chart entries are not scored
            if (rd_wait && mem_rdata.keys != '0) begin
                max_score <= max_score + score_t'(`MAX_PTS);
                if (ctrl.auto_play) begin
                    score <= score + score_t'(`AUTO_PTS);
                end else if (key_q.keys != '0) begin
                    hist0 <= key_q;
                    hist1 <= hist0;
                    if (mem_rdata == key_q) begin
                        score <= score + score_t'(`HIT_NOW_PTS);
                    end else if (mem_rdata == hist0) begin
                        score <= score + score_t'(`HIT_LATE1_PTS);
                    end else if (mem_rdata == hist1) begin
                        score <= score + score_t'(`HIT_LATE2_PTS);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/chart_player_top.sv */
`default_nettype none

module chart_player_top import chart_play_pkg::*; (
    input  logic       prog_clk,
    input  logic       rst,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  apb_data_t  pwdata,
    output apb_data_t  prdata,
    output logic       pready,
    output logic       pslverr,
    input  note_t      keys,
    output note_t      played_note,
    output logic       note_valid,
    output logic [7:0] led,
    output logic [1:0] count_digit
);

    mem_req_t    apb_req;
    mem_req_t    seq_req;
    mem_req_t    judge_req;
    logic        apb_gnt;
    logic        seq_gnt;
    logic        judge_gnt;
    note_t       rdata;
    play_ctrl_t  ctrl;
    play_state_e state;
    score_t      score;
    score_t      max_score;
    chart_addr_t note_idx;
    logic        scan_tick;

    chart_ram_arbiter u_arbiter (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .seq_req   (seq_req),
        .judge_req (judge_req),
        .apb_gnt   (apb_gnt),
        .seq_gnt   (seq_gnt),
        .judge_gnt (judge_gnt),
        .rdata     (rdata)
    );

    chart_apb_port u_apb (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .mem_req   (apb_req),
        .mem_gnt   (apb_gnt),
        .mem_rdata (rdata),
        .ctrl      (ctrl),
        .state     (state),
        .score     (score),
        .max_score (max_score)
    );

    note_sequencer u_seq (
        .prog_clk    (prog_clk),
        .rst         (rst),
        .ctrl        (ctrl),
        .keys        (keys),
        .mem_req     (seq_req),
        .mem_gnt     (seq_gnt),
        .mem_rdata   (rdata),
        .state       (state),
        .count_digit (count_digit),
        .note_idx    (note_idx),
        .note_step   (),
        .scan_tick   (scan_tick),
        .played_note (played_note),
        .note_valid  (note_valid),
        .led         (led)
    );

    score_judge u_judge (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .state     (state),
        .scan_tick (scan_tick),
        .note_idx  (note_idx),
        .keys      (keys),
        .mem_req   (judge_req),
        .mem_gnt   (judge_gnt),
        .mem_rdata (rdata),
        .score     (score),
        .max_score (max_score)
    );

endmodule

`default_nettype wire

/* tests/chart_player_assert.sv */
`default_nettype none

module chart_player_assert import chart_play_pkg::*; (
    input logic       prog_clk,
    input logic       rst,
    input logic       psel,
    input logic       penable,
    input logic       pready,
    input logic       note_valid,
    input logic [7:0] led,
    input score_t     score,
    input score_t     max_score
);

    a_pready_in_access: assert property (@(posedge prog_clk) disable iff (rst)
        pready |-> (psel && penable))
        else $error("pready high outside an APB access phase");

    a_note_valid_pulse: assert property (@(posedge prog_clk) disable iff (rst)
        note_valid |=> !note_valid)
        else $error("note_valid held longer than one cycle");

    // Both scores move on the same edge
    a_score_bounded: assert property (@(posedge prog_clk) disable iff (rst)
        score <= max_score)
        else $error("score above the maximum score");

    a_led_keys: assert property (@(posedge prog_clk) disable iff (rst)
        $onehot0(led[7:1]))
        else $error("more than one key LED lit");

endmodule

bind chart_player_top chart_player_assert u_checker (
    .prog_clk   (prog_clk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pready     (pready),
    .note_valid (note_valid),
    .led        (led),
    .score      (score),
    .max_score  (max_score)
);

`default_nettype wire

/* tests/chart_player_tb.sv */
`include "chart_play_settings.svh"
`default_nettype none

module chart_player_tb import chart_play_pkg::*; ();

    localparam int NOTES = 12;
    localparam int WAIT_LIMIT = 1000;
    localparam int POLL_LIMIT = 200;

    logic       prog_clk;
    logic       rst;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;
    note_t      keys;
    note_t      played_note;
    logic       note_valid;
    logic [7:0] led;
    logic [1:0] count_digit;

    // Reference copy of the chart memory
    note_t  chart_model [`CHART_LEN];
    int     scored_notes;
    score_t run_score;
    score_t run_max;

    chart_player_top DUT (
        .prog_clk    (prog_clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .keys        (keys),
        .played_note (played_note),
        .note_valid  (note_valid),
        .led         (led),
        .count_digit (count_digit)
    );

    initial begin
        prog_clk = 1'b0;
        forever #20 prog_clk = ~prog_clk;
    end

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at time %0t: gave up waiting for %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped on a timeout");
    endtask

    task automatic check_note(input note_t got, input note_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_score(input score_t got, input score_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_state(input play_state_e got, input play_state_e exp,
                               input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %s, expected %s", what, got.name(), exp.name()));
        end
    endtask

    task automatic check_led(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_int(input int got, input int exp, input string what);
        if (got != exp) begin
            report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    // Expected LED byte with the octave flag on bit 0 and C on bit 7
    function automatic logic [7:0] led_of(input note_t n);
        logic [7:0] l;
        l    = '0;
        l[0] = n.oct_up | n.oct_down;
        for (int i = 0; i < 7; i++) begin
            if (n.keys[i]) begin
                l[7 - i] = 1'b1;
            end
        end
        return l;
    endfunction

    // Single key or rest with any mix of octave shifts
    function automatic note_t random_note();
        note_t n;
        int    oct;
        n   = '0;
        oct = $urandom_range(3);
        if ($urandom_range(3) != 0) begin
            n.keys[$urandom_range(6)] = 1'b1;
        end
        if (oct[0]) begin
            n.oct_up = 1'b1;
        end
        if (oct[1]) begin
            n.oct_down = 1'b1;
        end
        return n;
    endfunction

    // Chords of two or more keys never equal a chart note
    function automatic note_t wrong_keys();
        note_t n;
        n = '0;
        if ($urandom_range(2) != 0) begin
            n.keys   = 7'($urandom()) | 7'b1000001;
            n.oct_up = 1'($urandom());
        end
        return n;
    endfunction

    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t data,
                            output apb_data_t rd, output logic err);
        int waited;
        waited = 0;
        @(negedge prog_clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge prog_clk);
        penable = 1'b1;
        // Chart accesses may stall until the arbiter grants them
        do begin
            @(negedge prog_clk);
            waited++;
            if (waited > POLL_LIMIT) begin
                report_timeout("pready in an APB access");
            end
        end while (!pready);
        rd  = prdata;
        err = pslverr;
        @(negedge prog_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        apb_data_t rd;
        logic      err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_int(int'(err), 0, $sformatf("pslverr on write to %h", addr));
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rd);
        logic err;
        apb_xfer(1'b0, addr, '0, rd, err);
        check_int(int'(err), 0, $sformatf("pslverr on read of %h", addr));
    endtask

    task automatic read_state(output play_state_e s);
        apb_data_t rd;
        apb_read(`ADDR_STATUS, rd);
        s = play_state_e'(rd[1:0]);
    endtask

    task automatic read_scores(output score_t sc, output score_t mx);
        apb_data_t rd;
        apb_read(`ADDR_SCORE, rd);
        sc = rd[13:0];
        mx = rd[29:16];
    endtask

    task automatic start_play(input logic auto_play);
        apb_write(`ADDR_CTRL, apb_data_t'({auto_play, 1'b1}));
    endtask

    task automatic wait_for_state(input play_state_e s);
        play_state_e cur;
        int          polls;
        polls = 0;
        read_state(cur);
        while (cur != s) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                report_timeout($sformatf("status %s", s.name()));
            end
            read_state(cur);
        end
    endtask

    task automatic wait_note_valid();
        int waited;
        waited = 0;
        do begin
            @(negedge prog_clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("note_valid");
            end
        end while (!note_valid);
    endtask

    // Follows the digits from start until the first note
    task automatic watch_countdown();
        int         held [4];
        int         next_digit;
        logic [1:0] last;
        int         waited;
        held       = '{default: 0};
        next_digit = 3;
        last       = 2'd0;
        waited     = 0;
        do begin
            @(negedge prog_clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("first note_valid after start");
            end
            if (count_digit != last && count_digit != 2'd0) begin
                check_int(int'(count_digit), next_digit, "countdown digit order");
                next_digit--;
            end
            last = count_digit;
            held[count_digit]++;
        end while (!note_valid);
        check_int(next_digit, 0, "countdown steps shown");
        check_int(held[3], `COUNT_TICKS, "cycles showing digit 3");
        check_int(held[2], `COUNT_TICKS, "cycles showing digit 2");
        check_int(held[1], `COUNT_TICKS, "cycles showing digit 1");
    endtask

    task automatic play_run(input logic auto_play, input logic exact,
                            output score_t sc, output score_t mx);
        play_state_e st;
        note_t       exp_played;
        @(negedge prog_clk);
        keys = '0;
        start_play(auto_play);
        for (int k = 0; k < NOTES; k++) begin
            if (k == 0) begin
                watch_countdown();
            end else begin
                wait_note_valid();
            end
            // User mode plays the keys held when the note arrives
            exp_played = auto_play ? chart_model[k] : keys;
            check_note(played_note, exp_played, $sformatf("played note %0d", k));
            check_led(led, led_of(chart_model[k]), $sformatf("led at note %0d", k));
            if (!auto_play) begin
                keys = exact ? chart_model[k] : wrong_keys();
            end
            if (k == 0) begin
                // No scan has run yet, so the start left both scores cleared
                read_scores(sc, mx);
                check_score(sc, '0, "score after start");
                check_score(mx, '0, "max score after start");
                start_play(1'b1);
                read_state(st);
                check_state(st, PLAYING, "status after start while playing");
            end
        end
        wait_for_state(DONE);
        keys = '0;
        read_scores(sc, mx);
    endtask

    initial begin
        play_state_e st;
        apb_data_t   rd;
        logic        err;
        score_t      sc;
        score_t      mx;
        score_t      exp_max;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        keys    = '0;
        rst     = 1'b1;
        void'($urandom(8));
        repeat (16) @(posedge prog_clk);
        @(negedge prog_clk);
        rst = 1'b0;

        check_int(int'(note_valid), 0, "note_valid after reset");
        check_int(int'(pready), 0, "pready after reset");
        check_int(int'(pslverr), 0, "pslverr after reset");
        check_note(played_note, '0, "played note after reset");
        check_led(led, '0, "led after reset");
        read_state(st);
        check_state(st, IDLE, "status after reset");
        read_scores(sc, mx);
        check_score(sc, '0, "score after reset");
        check_score(mx, '0, "max score after reset");

        // Chart load and readback
        for (int i = 0; i < `CHART_LEN; i++) begin
            chart_model[i] = random_note();
            apb_write(apb_addr_t'(i), apb_data_t'(chart_model[i]));
        end
        for (int i = 0; i < `CHART_LEN; i++) begin
            apb_read(apb_addr_t'(i), rd);
            check_note(note_t'(rd[8:0]), chart_model[i], $sformatf("chart word %0d", i));
        end
        apb_write(`ADDR_NOTE_CNT, NOTES);
        apb_read(`ADDR_NOTE_CNT, rd);
        check_int(int'(rd), NOTES, "note count readback");
        apb_xfer(1'b0, 8'h50, '0, rd, err);
        check_int(int'(err), 1, "pslverr on unmapped read");
        apb_xfer(1'b1, 8'hf3, 32'h1ff, rd, err);
        check_int(int'(err), 1, "pslverr on unmapped write");

        scored_notes = 0;
        for (int i = 0; i < NOTES; i++) begin
            if (chart_model[i].keys != '0) begin
                scored_notes++;
            end
        end
        exp_max = score_t'(`MAX_PTS * `NOTE_SCANS * scored_notes);

        play_run(1'b1, 1'b0, run_score, run_max);
        check_score(run_max, exp_max, "max score in auto-play");
        check_score(run_score, score_t'(exp_max * 4 / 5), "score in auto-play");

        play_run(1'b0, 1'b1, run_score, run_max);
        check_score(run_max, exp_max, "max score with exact keys");
        check_score(run_score, exp_max, "score with exact keys");

        play_run(1'b0, 1'b0, run_score, run_max);
        check_score(run_max, exp_max, "max score with missed keys");
        check_score(run_score, '0, "score with missed keys");

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/chart_play_pkg.sv
rtl/chart_ram_arbiter.sv
rtl/apb_chart_port.sv
rtl/note_sequencer.sv
rtl/score_judge.sv
rtl/chart_player_top.sv
tests/chart_player_assert.sv
tests/chart_player_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module chart_player_tb \
    -f files.f -Mdir obj_dir -o chart_player_sim
status=0
./obj_dir/chart_player_sim > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation did not finish cleanly"
    exit 1
fi
echo "Simulation passed"
